// ==== Bender.yml ====
package:
  name: ts_filter

sources:
  - common/ts_pkg.sv
  - monitor/pid_monitor.sv
  - replacer/pid_replacer.sv
  - verilog/ts_filter_regs.sv
  - verilog/ts_filter_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_ts_filter.sv

// ==== common/ts_pkg.sv ====
package ts_pkg;

	// transport packet geometry
	localparam int PACK_BYTES = 188;
	localparam int DATA_WIDTH = 32;
	localparam int PACK_WORDS = PACK_BYTES / (DATA_WIDTH / 8);

	localparam logic [7:0] TS_SYNC_BYTE = 8'h47;

	// host register word addresses
	localparam int ADDR_INDEX = 0;
	localparam int ADDR_PID = 1;
	localparam int ADDR_CMD = 2;
	localparam int ADDR_STATUS = 3;

	// packet window, PACK_WORDS long
	localparam int ADDR_DATA_BASE = 128;

	// returned for any unmapped read
	localparam logic [DATA_WIDTH-1:0] READ_FILL = 32'hFF00FF00;

	typedef enum logic [DATA_WIDTH-1:0] {
		CMD_NONE = 32'd0,
		CMD_WRITE_REPLACE = 32'd1,
		CMD_READ_REQUEST = 32'd2
	} reg_cmd_e;

	typedef enum logic [1:0] {
		CAP_IDLE,
		CAP_WAIT_START,
		CAP_STORE,
		CAP_DONE
	} cap_state_e;

endpackage

// ==== monitor/pid_monitor.sv ====
`timescale 1ns/1ps

module pid_monitor (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic [12:0] pid,
	input  logic capture_req,
	input  logic [7:0] mpeg_data,
	input  logic mpeg_valid,
	input  logic mpeg_sync,
	output logic cap_valid,
	output logic [ts_pkg::DATA_WIDTH-1:0] cap_data,
	output logic [$clog2(ts_pkg::PACK_WORDS)-1:0] cap_index,
	output logic cap_ready
);
	localparam int IDX_W = $clog2(ts_pkg::PACK_WORDS);

	ts_pkg::cap_state_e state;
	logic [7:0] byte_cnt;
	logic [23:0] word_buf;
	logic pkt_start;
	logic last_lane;

	assign pkt_start = mpeg_valid && mpeg_sync && (mpeg_data == ts_pkg::TS_SYNC_BYTE);
	assign last_lane = (byte_cnt[1:0] == 2'd3);

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			state <= ts_pkg::CAP_IDLE;
			byte_cnt <= '0;
			cap_valid <= 1'b0;
			cap_ready <= 1'b0;
		end else begin
			cap_valid <= 1'b0;
			if (capture_req) begin
				state <= ts_pkg::CAP_WAIT_START;
				cap_ready <= 1'b0;
			end else begin
				case (state)
					ts_pkg::CAP_WAIT_START: begin
						if (pkt_start) begin
							byte_cnt <= 8'd1;
							state <= ts_pkg::CAP_STORE;
						end
					end
					ts_pkg::CAP_STORE: begin
						if (mpeg_valid) begin
							byte_cnt <= byte_cnt + 8'd1;
							// pid complete on byte 2, otherwise wait for the next packet
							if (byte_cnt == 8'd2 && {word_buf[12:8], mpeg_data} != pid) begin
								state <= ts_pkg::CAP_WAIT_START;
							end else if (last_lane) begin
								cap_valid <= 1'b1;
								if (byte_cnt == 8'(ts_pkg::PACK_BYTES - 1))
									state <= ts_pkg::CAP_DONE;
							end
						end
					end
					ts_pkg::CAP_DONE: cap_ready <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// byte k into lane k mod 4 of word k/4
	always_ff @(posedge S_AXI_ACLK) begin
		if (state == ts_pkg::CAP_WAIT_START && pkt_start) begin
			word_buf[7:0] <= mpeg_data;
		end else if (state == ts_pkg::CAP_STORE && mpeg_valid) begin
			if (last_lane) begin
				cap_data <= {mpeg_data, word_buf};
				cap_index <= IDX_W'(byte_cnt[7:2]);
			end else begin
				word_buf[8*byte_cnt[1:0] +: 8] <= mpeg_data;
			end
		end
	end

	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		cap_valid |-> (cap_index < ts_pkg::PACK_WORDS));

endmodule

// ==== replacer/pid_replacer.sv ====
`timescale 1ns/1ps

module pid_replacer (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic [12:0] pid,
	input  logic capture_req,
	input  logic load_en,
	input  logic [ts_pkg::DATA_WIDTH-1:0] load_data,
	input  logic [$clog2(ts_pkg::PACK_WORDS)-1:0] load_index,
	input  logic [7:0] mpeg_data,
	input  logic mpeg_valid,
	input  logic mpeg_sync,
	output logic cap_valid,
	output logic [ts_pkg::DATA_WIDTH-1:0] cap_data,
	output logic [$clog2(ts_pkg::PACK_WORDS)-1:0] cap_index,
	output logic cap_ready,
	output logic [7:0] rep_data,
	output logic rep_matched
);
	logic [ts_pkg::DATA_WIDTH-1:0] rep_buf [ts_pkg::PACK_WORDS];
	logic [ts_pkg::DATA_WIDTH-1:0] buf_word;
	logic [7:0] buf_byte;
	logic [7:0] byte_cnt;
	logic [4:0] pid_hi;
	logic in_pkt;
	logic pkt_match;
	logic pkt_start;
	logic pid_hit;

	// capture sees the stream before substitution
	pid_monitor u_pid_monitor (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.pid(pid),
		.capture_req(capture_req),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.cap_valid(cap_valid),
		.cap_data(cap_data),
		.cap_index(cap_index),
		.cap_ready(cap_ready)
	);

	always_ff @(posedge S_AXI_ACLK) begin
		if (load_en)
			rep_buf[load_index] <= load_data;
	end

	assign buf_word = rep_buf[byte_cnt[7:2]];
	assign buf_byte = buf_word[8*byte_cnt[1:0] +: 8];
	assign pkt_start = mpeg_valid && mpeg_sync && (mpeg_data == ts_pkg::TS_SYNC_BYTE);
	assign pid_hit = ({pid_hi, mpeg_data} == pid);

	// bytes 0 and 1 are flagged before the pid is known
	// harmless since the header passes through unchanged
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			byte_cnt <= '0;
			in_pkt <= 1'b0;
			pkt_match <= 1'b0;
			rep_matched <= 1'b0;
		end else if (!mpeg_valid) begin
			rep_matched <= 1'b0;
		end else if (pkt_start) begin
			byte_cnt <= 8'd1;
			in_pkt <= 1'b1;
			pkt_match <= 1'b1;
			rep_matched <= 1'b1;
		end else if (in_pkt) begin
			if (byte_cnt == 8'(ts_pkg::PACK_BYTES - 1)) begin
				byte_cnt <= '0;
				in_pkt <= 1'b0;
			end else begin
				byte_cnt <= byte_cnt + 8'd1;
			end
			if (byte_cnt == 8'd2) begin
				pkt_match <= pid_hit;
				rep_matched <= pid_hit;
			end else begin
				rep_matched <= pkt_match;
			end
		end else begin
			rep_matched <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (mpeg_valid && in_pkt && !pkt_start && byte_cnt == 8'd1)
			pid_hi <= mpeg_data[4:0];
		if (in_pkt && pkt_match && !pkt_start && byte_cnt >= 8'd4)
			rep_data <= buf_byte;
		else
			rep_data <= mpeg_data;
	end

	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		rep_matched |-> $past(mpeg_valid));

endmodule

// ==== src.f ====
+incdir+testbench
common/ts_pkg.sv
monitor/pid_monitor.sv
replacer/pid_replacer.sv
verilog/ts_filter_regs.sv
verilog/ts_filter_top.sv
testbench/tb_ts_filter.sv

// ==== testbench/tb_ts_tasks.svh ====
task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("[FAIL] %0t: %s, got %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic check_cmd(input ts_pkg::reg_cmd_e got, input ts_pkg::reg_cmd_e exp,
		input string what);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("[FAIL] %0t: %s, got %h, expected %s", $time, what, got, exp.name());
	end
endtask

task automatic finish_test(input string name, input int errs_before);
	test_count++;
	if (err_count == errs_before) begin
		$display("test %s: ok", name);
	end else begin
		test_fails++;
		$display("test %s: %0d errors", name, err_count - errs_before);
	end
endtask

// returns one edge after the write is decoded
task automatic host_write(input int addr, input logic [31:0] data, input logic [3:0] strb);
	mem_wren = 1'b1;
	mem_address = ADDR_BITS'(addr);
	wdata = data;
	wstrb = strb;
	@(posedge S_AXI_ACLK);
	#1;
	mem_wren = 1'b0;
	@(posedge S_AXI_ACLK);
	#1;
endtask

task automatic host_read(input int addr, output logic [31:0] data);
	mem_rden = 1'b1;
	mem_address = ADDR_BITS'(addr);
	@(posedge S_AXI_ACLK);
	#1;
	data = rdata;
	mem_rden = 1'b0;
endtask

task automatic select_slot(input int slot);
	host_write(ts_pkg::ADDR_INDEX, 32'(slot), 4'hF);
endtask

task automatic build_packet(input logic [12:0] pid);
	pkt[0] = ts_pkg::TS_SYNC_BYTE;
	pkt[1] = {3'b010, pid[12:8]};
	pkt[2] = pid[7:0];
	pkt[3] = 8'h10;
	for (int k = 4; k < ts_pkg::PACK_BYTES; k++) begin
		pkt[k] = 8'($random(seed));
	end
endtask

// byte k of the packet in lane k mod 4 of word k/4
function automatic logic [31:0] pack_word(input int w);
	return {pkt[4*w+3], pkt[4*w+2], pkt[4*w+1], pkt[4*w]};
endfunction

// ts_out is checked two cycles after each input byte
task automatic stream_packet(input logic replace);
	for (int k = 0; k < ts_pkg::PACK_BYTES; k++) begin
		if (replace && k >= 4)
			exp_out[k] = rep_words[k / 4][8 * (k % 4) +: 8];
		else
			exp_out[k] = pkt[k];
	end
	for (int i = 0; i < ts_pkg::PACK_BYTES + 2; i++) begin
		@(posedge S_AXI_ACLK);
		#1;
		if (i >= 2)
			check_byte(ts_out, exp_out[i - 2], $sformatf("ts_out byte %0d", i - 2));
		// valid only once the first byte reaches the output
		check_word(32'(ts_out_valid), 32'(i >= 2), $sformatf("ts_out_valid step %0d", i));
		if (i < ts_pkg::PACK_BYTES) begin
			mpeg_data = pkt[i];
			mpeg_valid = 1'b1;
			mpeg_sync = (i == 0);
		end else begin
			mpeg_data = '0;
			mpeg_valid = 1'b0;
			mpeg_sync = 1'b0;
		end
	end
endtask

task automatic wait_ready();
	logic [31:0] status;
	int polls;
	status = '0;
	polls = 0;
	while (status[0] !== 1'b1 && polls < 300) begin
		host_read(ts_pkg::ADDR_STATUS, status);
		polls++;
	end
	if (status[0] !== 1'b1) begin
		err_count++;
		$display("error at %0t: the capture never completed, status stayed 0", $time);
	end
endtask

task automatic check_window();
	logic [31:0] data;
	for (int w = 0; w < ts_pkg::PACK_WORDS; w++) begin
		host_read(ts_pkg::ADDR_DATA_BASE + w, data);
		check_word(data, pack_word(w), $sformatf("window word %0d", w));
	end
endtask

task automatic load_replacement(input logic keep_model);
	logic [31:0] word;
	for (int w = 0; w < ts_pkg::PACK_WORDS; w++) begin
		word = $random(seed);
		if (keep_model)
			rep_words[w] = word;
		host_write(ts_pkg::ADDR_DATA_BASE + w, word, 4'hF);
	end
endtask

task automatic test_registers();
	logic [31:0] data;
	int errs_before;
	errs_before = err_count;
	select_slot(0);
	host_write(ts_pkg::ADDR_PID, 32'(PID_MON0), 4'hF);
	select_slot(2);
	host_write(ts_pkg::ADDR_PID, 32'(PID_REP), 4'hF);
	select_slot(3);
	host_write(ts_pkg::ADDR_PID, 32'(PID_SPARE), 4'hF);
	host_read(ts_pkg::ADDR_PID, data);
	check_word(data, 32'(PID_SPARE), "slot 3 pid readback");
	select_slot(1);
	host_read(ts_pkg::ADDR_INDEX, data);
	check_word(data, 32'd1, "index readback");
	host_write(ts_pkg::ADDR_PID, 32'(PID_MON1), 4'hF);
	host_read(ts_pkg::ADDR_PID, data);
	check_word(data, 32'(PID_MON1), "slot 1 pid readback");
	// out of range index is dropped
	select_slot(SLOT_NUM);
	host_read(ts_pkg::ADDR_INDEX, data);
	check_word(data, 32'd1, "index after slot count write");
	select_slot(200);
	host_read(ts_pkg::ADDR_INDEX, data);
	check_word(data, 32'd1, "index after large write");
	// only lane 0 changes so 0x101 becomes 0x15A
	host_write(ts_pkg::ADDR_PID, 32'hFFFF_FF5A, 4'b0001);
	host_read(ts_pkg::ADDR_PID, data);
	check_word(data, 32'h0000_015A, "pid after lane 0 write");
	host_write(ts_pkg::ADDR_PID, 32'(PID_MON1), 4'hF);
	host_write(ts_pkg::ADDR_CMD, ts_pkg::CMD_WRITE_REPLACE, 4'hF);
	host_read(ts_pkg::ADDR_CMD, data);
	check_cmd(ts_pkg::reg_cmd_e'(data), ts_pkg::CMD_WRITE_REPLACE, "command readback");
	host_write(ts_pkg::ADDR_CMD, ts_pkg::CMD_NONE, 4'hF);
	host_read(ts_pkg::ADDR_CMD, data);
	check_cmd(ts_pkg::reg_cmd_e'(data), ts_pkg::CMD_NONE, "command cleared");
	host_read(64, data);
	check_word(data, ts_pkg::READ_FILL, "unmapped read");
	finish_test("registers", errs_before);
endtask

task automatic test_monitor_capture();
	int errs_before;
	errs_before = err_count;
	select_slot(0);
	host_write(ts_pkg::ADDR_CMD, ts_pkg::CMD_READ_REQUEST, 4'hF);
	build_packet(PID_OTHER);
	stream_packet(1'b0);
	build_packet(PID_MON0);
	stream_packet(1'b0);
	wait_ready();
	check_window();
	finish_test("monitor capture", errs_before);
endtask

task automatic test_replacement();
	int errs_before;
	errs_before = err_count;
	select_slot(2);
	host_write(ts_pkg::ADDR_CMD, ts_pkg::CMD_WRITE_REPLACE, 4'hF);
	load_replacement(1'b1);
	build_packet(PID_REP);
	stream_packet(1'b1);
	build_packet(PID_OTHER);
	stream_packet(1'b0);
	finish_test("replacement", errs_before);
endtask

task automatic test_replacer_capture();
	int errs_before;
	errs_before = err_count;
	select_slot(2);
	host_write(ts_pkg::ADDR_CMD, ts_pkg::CMD_READ_REQUEST, 4'hF);
	build_packet(PID_REP);
	stream_packet(1'b1);
	wait_ready();
	// window holds the packet as it arrived
	check_window();
	finish_test("replacer capture", errs_before);
endtask

task automatic test_load_guard();
	int errs_before;
	errs_before = err_count;
	select_slot(1);
	host_write(ts_pkg::ADDR_CMD, ts_pkg::CMD_WRITE_REPLACE, 4'hF);
	load_replacement(1'b0);
	build_packet(PID_MON1);
	stream_packet(1'b0);
	// slot 2 still holds the earlier replacement
	build_packet(PID_REP);
	stream_packet(1'b1);
	// pid write between arm and data leaves slot 2 unloaded
	select_slot(2);
	host_write(ts_pkg::ADDR_CMD, ts_pkg::CMD_WRITE_REPLACE, 4'hF);
	host_write(ts_pkg::ADDR_PID, 32'(PID_REP), 4'hF);
	load_replacement(1'b0);
	build_packet(PID_REP);
	stream_packet(1'b1);
	finish_test("loading guard", errs_before);
endtask

// ==== testbench/tb_ts_filter.sv ====
`timescale 1ns/1ps

module tb_ts_filter;

	localparam int ADDR_BITS = 8;
	localparam int SLOT_NUM = 4;
	localparam int CYCLE_LIMIT = 6000;

	localparam logic [12:0] PID_MON0 = 13'h0100;
	localparam logic [12:0] PID_MON1 = 13'h0101;
	localparam logic [12:0] PID_REP = 13'h01A5;
	localparam logic [12:0] PID_SPARE = 13'h00F3;
	localparam logic [12:0] PID_OTHER = 13'h0333;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic mem_wren;
	logic mem_rden;
	logic [ADDR_BITS-1:0] mem_address;
	logic [ts_pkg::DATA_WIDTH-1:0] wdata;
	logic [ts_pkg::DATA_WIDTH/8-1:0] wstrb;
	logic [ts_pkg::DATA_WIDTH-1:0] rdata;
	logic [7:0] mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic [7:0] ts_out;
	logic ts_out_valid;

	integer seed;
	int err_count;
	int check_count;
	int test_count;
	int test_fails;
	int cycle_count = 0;

	// current packet, expected output and replacement contents
	logic [7:0] pkt [ts_pkg::PACK_BYTES];
	logic [7:0] exp_out [ts_pkg::PACK_BYTES];
	logic [31:0] rep_words [ts_pkg::PACK_WORDS];

	ts_filter_top #(
		.MONITOR_NUM(2),
		.REPLACER_NUM(2),
		.ADDR_BITS(ADDR_BITS)
	) u_ts_filter_top (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.mem_wren(mem_wren),
		.mem_rden(mem_rden),
		.mem_address(mem_address),
		.wdata(wdata),
		.wstrb(wstrb),
		.rdata(rdata),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.ts_out(ts_out),
		.ts_out_valid(ts_out_valid)
	);

	`include "tb_ts_tasks.svh"

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// about 20 packets of stream plus register traffic
	always @(posedge S_AXI_ACLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		seed = 32'h4aa37654;
		err_count = 0;
		check_count = 0;
		test_count = 0;
		test_fails = 0;
		S_AXI_ARESETN = 1'b0;
		mem_wren = 1'b0;
		mem_rden = 1'b0;
		mem_address = '0;
		wdata = '0;
		wstrb = '0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		repeat (4) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;

		test_registers();
		test_monitor_capture();
		test_replacement();
		test_replacer_capture();
		test_load_guard();

		$display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
			test_count, test_fails, check_count, err_count);
		if (err_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== verilog/ts_filter_regs.sv ====
`timescale 1ns/1ps

module ts_filter_regs #(
	parameter int MONITOR_NUM = 2,
	parameter int REPLACER_NUM = 2,
	parameter int ADDR_BITS = 8
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic mem_wren,
	input  logic mem_rden,
	input  logic [ADDR_BITS-1:0] mem_address,
	input  logic [ts_pkg::DATA_WIDTH-1:0] wdata,
	input  logic [ts_pkg::DATA_WIDTH/8-1:0] wstrb,
	input  logic [7:0] mpeg_data,
	input  logic mpeg_valid,
	input  logic mpeg_sync,
	output logic [ts_pkg::DATA_WIDTH-1:0] rdata,
	output logic [7:0] ts_out,
	output logic ts_out_valid
);
	localparam int SLOT_NUM = MONITOR_NUM + REPLACER_NUM;
	localparam int SLOT_BITS = (SLOT_NUM > 1) ? $clog2(SLOT_NUM) : 1;
	localparam int IDX_W = $clog2(ts_pkg::PACK_WORDS);
	localparam int DW = ts_pkg::DATA_WIDTH;

	logic [ADDR_BITS-1:0] wr_addr;
	logic [DW-1:0] wr_data;
	logic [DW/8-1:0] wr_strb;
	logic wr_pend;
	logic [DW-1:0] wr_old;
	logic [DW-1:0] wr_merged;
	logic [ADDR_BITS-1:0] wr_off;
	logic [ADDR_BITS-1:0] rd_off;
	logic wr_in_window;
	logic rd_in_window;

	logic [SLOT_BITS-1:0] cur_slot;
	logic [SLOT_BITS-1:0] req_owner;
	ts_pkg::reg_cmd_e cmd_q;
	logic [12:0] pid_tab [SLOT_NUM];
	logic [DW-1:0] cap_ram [ts_pkg::PACK_WORDS];
	logic [SLOT_NUM-1:0] cap_req;
	logic [REPLACER_NUM-1:0] rep_arm;
	logic [REPLACER_NUM-1:0] load_en;

	logic [SLOT_NUM-1:0] slot_cap_valid;
	logic [SLOT_NUM-1:0] slot_cap_ready;
	logic [DW-1:0] slot_cap_data [SLOT_NUM];
	logic [IDX_W-1:0] slot_cap_index [SLOT_NUM];
	logic [7:0] rep_data [REPLACER_NUM];
	logic [REPLACER_NUM-1:0] rep_matched;

	logic [7:0] in_data_q;
	logic in_valid_q;
	logic [7:0] sel_byte;

	function automatic logic [DW-1:0] merge_lanes(input logic [DW-1:0] old_val,
			input logic [DW-1:0] new_val, input logic [DW/8-1:0] strb);
		logic [DW-1:0] res;
		res = old_val;
		for (int b = 0; b < DW / 8; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_val[8*b +: 8];
		end
		return res;
	endfunction

	assign wr_off = wr_addr - ADDR_BITS'(ts_pkg::ADDR_DATA_BASE);
	assign rd_off = mem_address - ADDR_BITS'(ts_pkg::ADDR_DATA_BASE);
	assign wr_in_window = (wr_addr >= ts_pkg::ADDR_DATA_BASE) &&
		(wr_addr < ts_pkg::ADDR_DATA_BASE + ts_pkg::PACK_WORDS);
	assign rd_in_window = (mem_address >= ts_pkg::ADDR_DATA_BASE) &&
		(mem_address < ts_pkg::ADDR_DATA_BASE + ts_pkg::PACK_WORDS);

	// host write, captured now and decoded next cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (mem_wren) begin
			wr_addr <= mem_address;
			wr_data <= wdata;
			wr_strb <= wstrb;
		end
	end

	// unstrobed lanes keep the register's current contents
	always_comb begin
		case (wr_addr)
			ts_pkg::ADDR_INDEX: wr_old = DW'(cur_slot);
			ts_pkg::ADDR_PID: wr_old = DW'(pid_tab[cur_slot]);
			ts_pkg::ADDR_CMD: wr_old = cmd_q;
			default: wr_old = '0;
		endcase
	end

	assign wr_merged = merge_lanes(wr_old, wr_data, wr_strb);

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wr_pend <= 1'b0;
			cur_slot <= '0;
			req_owner <= '0;
			cmd_q <= ts_pkg::CMD_NONE;
			cap_req <= '0;
			rep_arm <= '0;
		end else begin
			wr_pend <= mem_wren;
			cap_req <= '0;
			if (wr_pend) begin
				if (!wr_in_window)
					rep_arm <= '0;
				if (wr_addr == ts_pkg::ADDR_INDEX && wr_merged < SLOT_NUM)
					cur_slot <= wr_merged[SLOT_BITS-1:0];
				if (wr_addr == ts_pkg::ADDR_CMD) begin
					cmd_q <= ts_pkg::reg_cmd_e'(wr_merged);
					if (wr_merged == ts_pkg::CMD_READ_REQUEST) begin
						cap_req[cur_slot] <= 1'b1;
						req_owner <= cur_slot;
					end
					// only replacer slots take a replacement packet
					if (wr_merged == ts_pkg::CMD_WRITE_REPLACE && cur_slot >= MONITOR_NUM)
						rep_arm[cur_slot - MONITOR_NUM] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_pend && wr_addr == ts_pkg::ADDR_PID)
			pid_tab[cur_slot] <= wr_merged[12:0];
	end

	// capture words from the slot that owns the last request
	always_ff @(posedge S_AXI_ACLK) begin
		if (slot_cap_valid[req_owner])
			cap_ram[slot_cap_index[req_owner]] <= slot_cap_data[req_owner];
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (mem_rden) begin
			case (mem_address)
				ts_pkg::ADDR_INDEX: rdata <= DW'(cur_slot);
				ts_pkg::ADDR_PID: rdata <= DW'(pid_tab[cur_slot]);
				ts_pkg::ADDR_CMD: rdata <= cmd_q;
				ts_pkg::ADDR_STATUS: rdata <= DW'(slot_cap_ready[cur_slot]);
				default: rdata <= rd_in_window ? cap_ram[rd_off[IDX_W-1:0]] : ts_pkg::READ_FILL;
			endcase
		end
	end

	for (genvar m = 0; m < MONITOR_NUM; m++) begin : g_mon
		pid_monitor u_pid_monitor (
			.S_AXI_ACLK(S_AXI_ACLK),
			.S_AXI_ARESETN(S_AXI_ARESETN),
			.pid(pid_tab[m]),
			.capture_req(cap_req[m]),
			.mpeg_data(mpeg_data),
			.mpeg_valid(mpeg_valid),
			.mpeg_sync(mpeg_sync),
			.cap_valid(slot_cap_valid[m]),
			.cap_data(slot_cap_data[m]),
			.cap_index(slot_cap_index[m]),
			.cap_ready(slot_cap_ready[m])
		);
	end

	for (genvar r = 0; r < REPLACER_NUM; r++) begin : g_rep
		assign load_en[r] = wr_pend && wr_in_window && rep_arm[r];

		pid_replacer u_pid_replacer (
			.S_AXI_ACLK(S_AXI_ACLK),
			.S_AXI_ARESETN(S_AXI_ARESETN),
			.pid(pid_tab[MONITOR_NUM + r]),
			.capture_req(cap_req[MONITOR_NUM + r]),
			.load_en(load_en[r]),
			.load_data(wr_merged),
			.load_index(wr_off[IDX_W-1:0]),
			.mpeg_data(mpeg_data),
			.mpeg_valid(mpeg_valid),
			.mpeg_sync(mpeg_sync),
			.cap_valid(slot_cap_valid[MONITOR_NUM + r]),
			.cap_data(slot_cap_data[MONITOR_NUM + r]),
			.cap_index(slot_cap_index[MONITOR_NUM + r]),
			.cap_ready(slot_cap_ready[MONITOR_NUM + r]),
			.rep_data(rep_data[r]),
			.rep_matched(rep_matched[r])
		);
	end

	// lowest matched replacer wins
	always_comb begin
		sel_byte = in_data_q;
		for (int r = REPLACER_NUM - 1; r >= 0; r--) begin
			if (rep_matched[r])
				sel_byte = rep_data[r];
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		in_data_q <= mpeg_data;
		ts_out <= sel_byte;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			in_valid_q <= 1'b0;
			ts_out_valid <= 1'b0;
		end else begin
			in_valid_q <= mpeg_valid;
			ts_out_valid <= in_valid_q;
		end
	end

	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(mem_wren && mem_rden));

endmodule

// ==== verilog/ts_filter_top.sv ====
`timescale 1ns/1ps

module ts_filter_top #(
	parameter int MONITOR_NUM = 2,
	parameter int REPLACER_NUM = 2,
	parameter int ADDR_BITS = 8
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	input  logic mem_wren,
	input  logic mem_rden,
	input  logic [ADDR_BITS-1:0] mem_address,
	input  logic [ts_pkg::DATA_WIDTH-1:0] wdata,
	input  logic [ts_pkg::DATA_WIDTH/8-1:0] wstrb,
	output logic [ts_pkg::DATA_WIDTH-1:0] rdata,
	input  logic [7:0] mpeg_data,
	input  logic mpeg_valid,
	input  logic mpeg_sync,
	output logic [7:0] ts_out,
	output logic ts_out_valid
);

	ts_filter_regs #(
		.MONITOR_NUM(MONITOR_NUM),
		.REPLACER_NUM(REPLACER_NUM),
		.ADDR_BITS(ADDR_BITS)
	) u_ts_filter_regs (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.mem_wren(mem_wren),
		.mem_rden(mem_rden),
		.mem_address(mem_address),
		.wdata(wdata),
		.wstrb(wstrb),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.rdata(rdata),
		.ts_out(ts_out),
		.ts_out_valid(ts_out_valid)
	);

endmodule
